//--- logic/blit_settings.svh
`ifndef BLIT_SETTINGS_SVH
`define BLIT_SETTINGS_SVH

// Framebuffer size in pixels
`define BLIT_FB_WIDTH 400
`define BLIT_FB_HEIGHT 240

// Coordinates and rectangle sizes
`define BLIT_COORD_W 16

// AXI-lite read channel
`define BLIT_ADDR_W 32
`define BLIT_DATA_W 32

`define BLIT_COLOUR_W 16     // Framebuffer pixel width

// Request queue entries
`define BLIT_FIFO_DEPTH 4

`endif

//--- logic/blit_pkg.sv
`include "blit_settings.svh"

package blit_pkg;

    // Bits per pixel, numeric value is the depth
    typedef enum logic [4:0] {
        DEPTH_1  = 5'd1,
        DEPTH_2  = 5'd2,
        DEPTH_4  = 5'd4,
        DEPTH_8  = 5'd8,
        DEPTH_16 = 5'd16
    } pix_depth_t;

    // One source pixel on its way to the framebuffer
    typedef struct packed {
        logic [`BLIT_ADDR_W-1:0]  addr;     // Word aligned
        logic [4:0]               offset;   // Bit position in the word
        pix_depth_t               depth;
        logic [`BLIT_COORD_W-1:0] x;
        logic [`BLIT_COORD_W-1:0] y;
    } pix_req_t;

endpackage

//--- logic/pixel_req_if.sv
`timescale 1ns/1ps

interface pixel_req_if;
    import blit_pkg::*;

    logic     valid;
    logic     ready;
    pix_req_t item;

    // Producer side
    modport src (
        output valid,
        output item,
        input  ready
    );

    // Consumer side
    modport dst (
        input  valid,
        input  item,
        output ready
    );

endinterface

//--- logic/rect_walker.sv
`timescale 1ns/1ps
`include "blit_settings.svh"

module rect_walker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`BLIT_ADDR_W-1:0]  image_start,
    input  logic [`BLIT_COORD_W-1:0] image_width,
    input  logic [`BLIT_COORD_W-1:0] src_x,
    input  logic [`BLIT_COORD_W-1:0] src_y,
    input  logic [`BLIT_COORD_W-1:0] rect_width,
    input  logic [`BLIT_COORD_W-1:0] rect_height,
    input  logic [`BLIT_COORD_W-1:0] screen_x,
    input  logic [`BLIT_COORD_W-1:0] screen_y,
    input  logic                     mirror_x,
    input  logic                     mirror_y,
    input  blit_pkg::pix_depth_t     depth,
    input  logic                     draw,
    output logic                     idle,
    pixel_req_if.src                 walk_q
);
    import blit_pkg::*;

    logic [`BLIT_ADDR_W-1:0]  base_r;
    logic [`BLIT_COORD_W-1:0] img_w_r;
    logic [`BLIT_COORD_W-1:0] src_x_r;
    logic [`BLIT_COORD_W-1:0] src_y_r;
    logic [`BLIT_COORD_W-1:0] rect_w_r;
    logic [`BLIT_COORD_W-1:0] rect_h_r;
    logic [`BLIT_COORD_W-1:0] scr_x_r;
    logic [`BLIT_COORD_W-1:0] scr_y_r;
    logic                     mirror_x_r;
    logic                     mirror_y_r;
    pix_depth_t               depth_r;

    logic [`BLIT_COORD_W-1:0] col;
    logic [`BLIT_COORD_W-1:0] row;
    logic                     empty_rect;
    logic                     last_col;
    logic                     last_row;
    logic [`BLIT_COORD_W:0]   pos_x;    // One extra bit so the clip test sees overflow
    logic [`BLIT_COORD_W:0]   pos_y;
    logic [`BLIT_ADDR_W-1:0]  pix_index;
    logic [`BLIT_ADDR_W-1:0]  bit_addr;
    logic                     keep;
    logic                     advance;
    pix_req_t                 item;

    assign empty_rect = rect_w_r == '0 || rect_h_r == '0;
    assign last_col   = col == rect_w_r - 1'b1;
    assign last_row   = row == rect_h_r - 1'b1;

    always_comb begin
        if (mirror_x_r)
            pos_x = {1'b0, scr_x_r} + {1'b0, rect_w_r - 1'b1 - col};
        else
            pos_x = {1'b0, scr_x_r} + {1'b0, col};
        if (mirror_y_r)
            pos_y = {1'b0, scr_y_r} + {1'b0, rect_h_r - 1'b1 - row};
        else
            pos_y = {1'b0, scr_y_r} + {1'b0, row};
    end

    // Source pixel index in the packed sheet, then its bit address
    assign pix_index = (`BLIT_ADDR_W'(src_y_r) + `BLIT_ADDR_W'(row)) * `BLIT_ADDR_W'(img_w_r)
                     + `BLIT_ADDR_W'(src_x_r) + `BLIT_ADDR_W'(col);
    assign bit_addr  = pix_index * `BLIT_ADDR_W'(depth_r);

    always_comb begin
        item.addr   = base_r + {3'b000, bit_addr[`BLIT_ADDR_W-1:5], 2'b00};
        item.offset = bit_addr[4:0];
        item.depth  = depth_r;
        item.x      = pos_x[`BLIT_COORD_W-1:0];
        item.y      = pos_y[`BLIT_COORD_W-1:0];
    end

    assign keep    = !empty_rect && pos_x < `BLIT_FB_WIDTH && pos_y < `BLIT_FB_HEIGHT;
    assign advance = !idle && !empty_rect && (!keep || walk_q.ready);   // Off-screen pixels just step

    assign walk_q.valid = !idle && keep;
    assign walk_q.item  = item;

    always_ff @(posedge clk) begin
        if (idle && draw) begin
            base_r     <= image_start;
            img_w_r    <= image_width;
            src_x_r    <= src_x;
            src_y_r    <= src_y;
            rect_w_r   <= rect_width;
            rect_h_r   <= rect_height;
            scr_x_r    <= screen_x;
            scr_y_r    <= screen_y;
            mirror_x_r <= mirror_x;
            mirror_y_r <= mirror_y;
            depth_r    <= depth;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idle <= 1'b1;
            col  <= '0;
            row  <= '0;
        end else if (idle) begin
            if (draw) begin
                idle <= 1'b0;
                col  <= '0;
                row  <= '0;
            end
        end else if (empty_rect) begin
            idle <= 1'b1;   // Nothing to walk
        end else if (advance) begin
            if (last_col) begin
                col <= '0;
                if (last_row)
                    idle <= 1'b1;
                else
                    row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

//--- logic/req_fifo.sv
`timescale 1ns/1ps
`include "blit_settings.svh"

module req_fifo (
    input  logic     clk,
    input  logic     rst,
    pixel_req_if.dst in,
    pixel_req_if.src out,
    output logic     empty
);
    import blit_pkg::*;

    localparam int DEPTH = `BLIT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    pix_req_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in.ready  = count != DEPTH;
    assign out.valid = count != '0;
    assign out.item  = mem[rd_ptr];
    assign empty     = count == '0;

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in.item;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop leaves the count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- logic/texel_fetch.sv
`timescale 1ns/1ps
`include "blit_settings.svh"

module texel_fetch (
    input  logic                      clk,
    input  logic                      rst,
    pixel_req_if.dst                  req,
    output logic [`BLIT_ADDR_W-1:0]   m_axil_araddr,
    output logic                      m_axil_arvalid,
    input  logic                      m_axil_arready,
    input  logic [`BLIT_DATA_W-1:0]   m_axil_rdata,
    input  logic                      m_axil_rvalid,
    output logic                      m_axil_rready,
    output logic [`BLIT_COORD_W-1:0]  fb_x,
    output logic [`BLIT_COORD_W-1:0]  fb_y,
    output logic [`BLIT_COLOUR_W-1:0] fb_colour,
    output logic                      fb_write,
    output logic                      idle
);
    import blit_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        WRITE
    } state_t;

    state_t                  state;
    logic [`BLIT_DATA_W-1:0] cache_word;
    logic [`BLIT_ADDR_W-1:0] cache_addr;
    logic                    cache_valid;
    logic                    cache_hit;
    logic                    accept;
    logic [4:0]              pend_offset;   // Offset and depth of the pixel waiting on AXI
    pix_depth_t              pend_depth;

    // Pixels sit at the low end after the shift
    function automatic logic [`BLIT_COLOUR_W-1:0] extract(
        input logic [`BLIT_DATA_W-1:0] word,
        input logic [4:0]              offset,
        input pix_depth_t              depth
    );
        logic [`BLIT_DATA_W-1:0] mask;
        logic [`BLIT_DATA_W-1:0] shifted;
        mask    = (`BLIT_DATA_W'(1) << depth) - 1'b1;
        shifted = word >> offset;
        return `BLIT_COLOUR_W'(shifted & mask);
    endfunction

    assign req.ready      = state == IDLE;
    assign accept         = req.valid && req.ready;
    assign cache_hit      = cache_valid && cache_addr == req.item.addr;
    assign m_axil_arvalid = state == ADDR;
    assign m_axil_rready  = state == DATA;
    assign fb_write       = state == WRITE;
    assign idle           = state == IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept)
                        state <= cache_hit ? WRITE : ADDR;
                end
                ADDR: begin
                    if (m_axil_arready)
                        state <= DATA;
                end
                DATA: begin
                    if (m_axil_rvalid) begin
                        state       <= WRITE;
                        cache_valid <= 1'b1;
                    end
                end
                WRITE: state <= IDLE;   // Back to IDLE for the next request
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fb_x          <= req.item.x;
            fb_y          <= req.item.y;
            m_axil_araddr <= req.item.addr;
            pend_offset   <= req.item.offset;
            pend_depth    <= req.item.depth;
            if (cache_hit)
                fb_colour <= extract(cache_word, req.item.offset, req.item.depth);
        end
        if (state == DATA && m_axil_rvalid) begin
            cache_word <= m_axil_rdata;
            cache_addr <= m_axil_araddr;
            fb_colour  <= extract(m_axil_rdata, pend_offset, pend_depth);
        end
    end

endmodule

//--- logic/blitter_top.sv
`timescale 1ns/1ps
`include "blit_settings.svh"

module blitter_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`BLIT_ADDR_W-1:0]   image_start,
    input  logic [`BLIT_COORD_W-1:0]  image_width,
    input  logic [`BLIT_COORD_W-1:0]  src_x,
    input  logic [`BLIT_COORD_W-1:0]  src_y,
    input  logic [`BLIT_COORD_W-1:0]  rect_width,
    input  logic [`BLIT_COORD_W-1:0]  rect_height,
    input  logic [`BLIT_COORD_W-1:0]  screen_x,
    input  logic [`BLIT_COORD_W-1:0]  screen_y,
    input  logic                      mirror_x,
    input  logic                      mirror_y,
    input  blit_pkg::pix_depth_t      depth,
    input  logic                      draw,
    output logic                      busy,
    output logic [`BLIT_ADDR_W-1:0]   m_axil_araddr,
    output logic                      m_axil_arvalid,
    input  logic                      m_axil_arready,
    input  logic [`BLIT_DATA_W-1:0]   m_axil_rdata,
    input  logic                      m_axil_rvalid,
    output logic                      m_axil_rready,
    output logic [`BLIT_COORD_W-1:0]  fb_x,
    output logic [`BLIT_COORD_W-1:0]  fb_y,
    output logic [`BLIT_COLOUR_W-1:0] fb_colour,
    output logic                      fb_write
);

    logic walk_idle;
    logic queue_empty;
    logic fetch_idle;
    logic draw_go;

    pixel_req_if walk_q ();
    pixel_req_if fetch_q ();

    assign busy    = !(walk_idle && queue_empty && fetch_idle);
    assign draw_go = draw && !busy;     // Commands only land on an idle pipeline

    rect_walker i_rect_walker (
        .clk         (clk),
        .rst         (rst),
        .image_start (image_start),
        .image_width (image_width),
        .src_x       (src_x),
        .src_y       (src_y),
        .rect_width  (rect_width),
        .rect_height (rect_height),
        .screen_x    (screen_x),
        .screen_y    (screen_y),
        .mirror_x    (mirror_x),
        .mirror_y    (mirror_y),
        .depth       (depth),
        .draw        (draw_go),
        .idle        (walk_idle),
        .walk_q      (walk_q.src)
    );

    req_fifo i_req_fifo (
        .clk   (clk),
        .rst   (rst),
        .in    (walk_q.dst),
        .out   (fetch_q.src),
        .empty (queue_empty)
    );

    texel_fetch i_texel_fetch (
        .clk            (clk),
        .rst            (rst),
        .req            (fetch_q.dst),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rready  (m_axil_rready),
        .fb_x           (fb_x),
        .fb_y           (fb_y),
        .fb_colour      (fb_colour),
        .fb_write       (fb_write),
        .idle           (fetch_idle)
    );

endmodule

//--- sim/axil_mem_model.sv
`timescale 1ns/1ps

module axil_mem_model #(
    parameter logic [31:0] DATA_KEY = 32'h5A3C_96E1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        slow,      // Random wait states on both channels
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready = 1'b0,
    output logic [31:0] rdata = '0,
    output logic        rvalid = 1'b0,
    input  logic        rready
);

    integer      seed = 50295;
    int          phase = 0;
    int          delay = 0;
    logic [31:0] addr_q = '0;
    logic        r_taken = 1'b0;    // Read data handshake on this edge

    // Outputs change 1 ns after the edge, like the rest of the stimulus
    always @(posedge clk) begin
        r_taken = rvalid && rready;
        #1;
        if (rst) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            phase   = 0;
        end else begin
            case (phase)
                0: if (arvalid) begin
                    delay = slow ? ($random(seed) & 7) : 0;
                    phase = 1;
                end
                1: if (delay > 0) begin
                    delay = delay - 1;
                end else begin
                    arready = 1'b1;
                    addr_q  = araddr;
                    phase   = 2;
                end
                2: begin
                    arready = 1'b0;    // Address taken on the last edge
                    delay   = slow ? ($random(seed) & 7) : 0;
                    phase   = 3;
                end
                3: if (delay > 0) begin
                    delay = delay - 1;
                end else begin
                    rvalid = 1'b1;
                    rdata  = addr_q ^ DATA_KEY;
                    phase  = 4;
                end
                default: begin
                    // Data stays up until the master takes it
                    if (r_taken) begin
                        rvalid = 1'b0;
                        phase  = 0;
                    end
                end
            endcase
        end
    end

endmodule

//--- sim/blitter_tb.sv
`timescale 1ns/1ps
`include "blit_settings.svh"

module blitter_tb;
    import blit_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_CMDS   = 16;
    localparam int MAX_PIX    = 32;    // Largest rectangle in the table is 24
    localparam int PIX_CYCLES = 24;    // Slow bus worst case plus pipeline
    localparam logic [31:0] DATA_KEY = 32'h5A3C_96E1;

    typedef struct packed {
        logic [31:0] image_start;
        logic [15:0] image_width;
        logic [15:0] src_x;
        logic [15:0] src_y;
        logic [15:0] rect_w;
        logic [15:0] rect_h;
        logic [15:0] scr_x;
        logic [15:0] scr_y;
        logic        mirror_x;
        logic        mirror_y;
        pix_depth_t  depth;
        logic        slow;
    } cmd_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] colour;
    } pix_exp_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] image_start;
    logic [15:0] image_width;
    logic [15:0] src_x;
    logic [15:0] src_y;
    logic [15:0] rect_width;
    logic [15:0] rect_height;
    logic [15:0] screen_x;
    logic [15:0] screen_y;
    logic        mirror_x;
    logic        mirror_y;
    pix_depth_t  depth;
    logic        draw;
    logic        slow_bus;
    logic        busy;
    logic [31:0] m_axil_araddr;
    logic        m_axil_arvalid;
    logic        m_axil_arready;
    logic [31:0] m_axil_rdata;
    logic        m_axil_rvalid;
    logic        m_axil_rready;
    logic [15:0] fb_x;
    logic [15:0] fb_y;
    logic [15:0] fb_colour;
    logic        fb_write;

    cmd_t        cmds [NUM_CMDS];
    pix_exp_t    exp_q [$];
    pix_exp_t    seen_pix;
    logic [31:0] exp_ar_q [$];         // Word addresses the cache cannot serve
    logic [31:0] seen_addr;
    int          ar_count = 0;
    int          exp_reads;
    logic        cache_known = 1'b0;     // Tracks the DUT's one-word cache
    int          cache_addr = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    blitter_top i_blitter_top (
        .clk            (clk),
        .rst            (rst),
        .image_start    (image_start),
        .image_width    (image_width),
        .src_x          (src_x),
        .src_y          (src_y),
        .rect_width     (rect_width),
        .rect_height    (rect_height),
        .screen_x       (screen_x),
        .screen_y       (screen_y),
        .mirror_x       (mirror_x),
        .mirror_y       (mirror_y),
        .depth          (depth),
        .draw           (draw),
        .busy           (busy),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rready  (m_axil_rready),
        .fb_x           (fb_x),
        .fb_y           (fb_y),
        .fb_colour      (fb_colour),
        .fb_write       (fb_write)
    );

    axil_mem_model #(.DATA_KEY(DATA_KEY)) i_axil_mem_model (
        .clk     (clk),
        .rst     (rst),
        .slow    (slow_bus),
        .araddr  (m_axil_araddr),
        .arvalid (m_axil_arvalid),
        .arready (m_axil_arready),
        .rdata   (m_axil_rdata),
        .rvalid  (m_axil_rvalid),
        .rready  (m_axil_rready)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            fail_run($sformatf("mismatch at %0d ns: %s is 0x%0h, expected 0x%0h",
                               $time, name, got, expected));
    endtask

    // Expected pixels in walk order, and the reads the cache cannot save
    task automatic build_expected(input cmd_t c);
        int          sx;
        int          sy;
        int          idx;
        int          bit_addr;
        int          word_addr;
        logic [31:0] word;
        logic [15:0] colour;
        exp_reads = 0;
        for (int row = 0; row < int'(c.rect_h); row++) begin
            for (int col = 0; col < int'(c.rect_w); col++) begin
                sx = c.mirror_x ? int'(c.scr_x) + int'(c.rect_w) - 1 - col : int'(c.scr_x) + col;
                sy = c.mirror_y ? int'(c.scr_y) + int'(c.rect_h) - 1 - row : int'(c.scr_y) + row;
                if (sx >= `BLIT_FB_WIDTH || sy >= `BLIT_FB_HEIGHT)
                    continue;
                idx       = (int'(c.src_y) + row) * int'(c.image_width) + int'(c.src_x) + col;
                bit_addr  = idx * int'(c.depth);
                word_addr = int'(c.image_start) + 4 * (bit_addr / 32);
                word      = 32'(word_addr) ^ DATA_KEY;
                colour    = 16'((64'(word) >> (bit_addr % 32)) & ((64'd1 << int'(c.depth)) - 1));
                if (!cache_known || word_addr != cache_addr) begin
                    exp_reads   = exp_reads + 1;
                    cache_known = 1'b1;
                    cache_addr  = word_addr;
                    exp_ar_q.push_back(32'(word_addr));
                end
                exp_q.push_back('{x: 16'(sx), y: 16'(sy), colour: colour});
            end
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic run_command(input cmd_t c);
        int cycles;
        int ar_start;
        build_expected(c);
        ar_start    = ar_count;
        slow_bus    = c.slow;
        image_start = c.image_start;
        image_width = c.image_width;
        src_x       = c.src_x;
        src_y       = c.src_y;
        rect_width  = c.rect_w;
        rect_height = c.rect_h;
        screen_x    = c.scr_x;
        screen_y    = c.scr_y;
        mirror_x    = c.mirror_x;
        mirror_y    = c.mirror_y;
        depth       = c.depth;
        draw        = 1'b1;
        @(posedge clk);
        #1;
        draw = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        cycles = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if ((c.rect_w == 16'd0 || c.rect_h == 16'd0) && cycles > 2)
            fail_run("busy stayed high too long for an empty rectangle");
        check_value("pending writes", 32'(exp_q.size()), 32'd0);
        check_value("read handshakes", 32'(ar_count - ar_start), 32'(exp_reads));
    endtask

    // Scoreboard, sampled on the falling edge where everything is settled
    always @(negedge clk) begin
        if (!rst && m_axil_arvalid && m_axil_arready) begin
            ar_count <= ar_count + 1;
            if (exp_ar_q.size() == 0) begin
                fail_run("read address handshake with no read left to expect");
            end else begin
                seen_addr = exp_ar_q.pop_front();
                check_value("m_axil_araddr", m_axil_araddr, seen_addr);
            end
        end
        if (!rst && fb_write) begin
            if (exp_q.size() == 0) begin
                fail_run("fb_write pulsed with no pixel left to expect");
            end else begin
                seen_pix = exp_q.pop_front();
                check_value("fb_x", 32'(fb_x), 32'(seen_pix.x));
                check_value("fb_y", 32'(fb_y), 32'(seen_pix.y));
                check_value("fb_colour", 32'(fb_colour), 32'(seen_pix.colour));
                check_value("busy", 32'(busy), 32'd1);
            end
        end
    end

    initial begin
        #(NUM_CMDS * MAX_PIX * PIX_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        fail_run("timeout: the command table did not finish in the allowed time");
    end

    initial begin
        rst         = 1'b1;
        draw        = 1'b0;
        slow_bus    = 1'b0;
        image_start = '0;
        image_width = '0;
        src_x       = '0;
        src_y       = '0;
        rect_width  = '0;
        rect_height = '0;
        screen_x    = '0;
        screen_y    = '0;
        mirror_x    = 1'b0;
        mirror_y    = 1'b0;
        depth       = DEPTH_8;
        // start, width, src x/y, rect w/h, screen x/y, mirror x/y, depth, slow bus
        cmds = '{
            '{32'h1000, 16'd64, 16'd3, 16'd2, 16'd6, 16'd3, 16'd10, 16'd20, 1'b0, 1'b0, DEPTH_8, 1'b0},
            '{32'h1000, 16'd64, 16'd3, 16'd2, 16'd5, 16'd2, 16'd100, 16'd50, 1'b1, 1'b0, DEPTH_8, 1'b0},
            '{32'h2000, 16'd32, 16'd0, 16'd4, 16'd4, 16'd3, 16'd0, 16'd0, 1'b0, 1'b1, DEPTH_8, 1'b0},
            '{32'h2000, 16'd32, 16'd5, 16'd1, 16'd3, 16'd3, 16'd200, 16'd120, 1'b1, 1'b1, DEPTH_8, 1'b0},
            '{32'h3000, 16'd100, 16'd27, 16'd1, 16'd7, 16'd2, 16'd50, 16'd60, 1'b0, 1'b0, DEPTH_1, 1'b0},
            '{32'h3400, 16'd40, 16'd14, 16'd0, 16'd5, 16'd2, 16'd60, 16'd70, 1'b0, 1'b0, DEPTH_2, 1'b0},
            '{32'h3800, 16'd20, 16'd6, 16'd1, 16'd4, 16'd2, 16'd70, 16'd80, 1'b0, 1'b0, DEPTH_4, 1'b0},
            '{32'h3c00, 16'd10, 16'd1, 16'd1, 16'd3, 16'd2, 16'd80, 16'd90, 1'b0, 1'b0, DEPTH_16, 1'b0},
            '{32'h1000, 16'd64, 16'd0, 16'd0, 16'd6, 16'd2, 16'd397, 16'd10, 1'b0, 1'b0, DEPTH_8, 1'b0},
            '{32'h2000, 16'd32, 16'd2, 16'd2, 16'd4, 16'd4, 16'd398, 16'd238, 1'b1, 1'b1, DEPTH_8, 1'b0},
            '{32'h1000, 16'd64, 16'd0, 16'd0, 16'd0, 16'd3, 16'd5, 16'd5, 1'b0, 1'b0, DEPTH_8, 1'b0},
            '{32'h1000, 16'd64, 16'd0, 16'd0, 16'd4, 16'd0, 16'd5, 16'd5, 1'b0, 1'b0, DEPTH_8, 1'b0},
            '{32'h3800, 16'd20, 16'd3, 16'd0, 16'd8, 16'd3, 16'd30, 16'd30, 1'b0, 1'b0, DEPTH_4, 1'b1},
            '{32'h3000, 16'd100, 16'd25, 16'd2, 16'd8, 16'd2, 16'd40, 16'd40, 1'b1, 1'b1, DEPTH_1, 1'b1},
            '{32'h3c00, 16'd10, 16'd0, 16'd0, 16'd6, 16'd2, 16'd396, 16'd100, 1'b0, 1'b0, DEPTH_16, 1'b1},
            '{32'h1000, 16'd64, 16'd3, 16'd2, 16'd6, 16'd3, 16'd10, 16'd20, 1'b0, 1'b1, DEPTH_8, 1'b1}
        };
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("busy", 32'(busy), 32'd0);
        check_value("fb_write", 32'(fb_write), 32'd0);
        check_value("m_axil_arvalid", 32'(m_axil_arvalid), 32'd0);
        check_value("m_axil_rready", 32'(m_axil_rready), 32'd0);
        for (int i = 0; i < NUM_CMDS; i++) begin
            run_command(cmds[i]);
            $display("command %0d done", i);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/blit_pkg.sv
logic/pixel_req_if.sv
logic/rect_walker.sv
logic/req_fifo.sv
logic/texel_fetch.sv
logic/blitter_top.sv
sim/axil_mem_model.sv
sim/blitter_tb.sv

//--- Makefile
# Verilator build and run of the blitter testbench

TOP = blitter_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 --top-module $(TOP) -f compile.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir sim.log
